// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --timescale 1ns/100ps -j 0
TOP       := wed_fetch_tb
FILELIST  := wed_fetch_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TESTS PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/capi_pkg.sv ====
package capi_pkg;

  //////////////////////////////////////////////////
  // Host interface widths
  //////////////////////////////////////////////////

  localparam int TAG_W      = 8;   // Command and response tag
  localparam int ADDR_W     = 64;  // Host effective address
  localparam int HALF_W     = 512; // One buffer write beat
  localparam int BUF_ADDR_W = 6;   // Buffer write address
  localparam int SIZE_W     = 12;  // Command byte count

  // Tag kept apart for the descriptor read
  localparam logic [TAG_W-1:0] WED_TAG = 8'hFE;

  // Full 128 byte cacheline
  localparam logic [SIZE_W-1:0] WED_READ_SIZE = 12'h080;

  //////////////////////////////////////////////////
  // Command and response codes
  //////////////////////////////////////////////////

  typedef enum logic [12:0] {
    INVALID    = 13'h0000, // No command
    READ_CL_NA = 13'h0A00  // Read line, no allocation
  } capi_command_t;

  typedef enum logic [7:0] {
    DONE   = 8'h00, // Command completed
    AERROR = 8'h01, // Address translation error
    FAILED = 8'h08, // Command failed
    PAGED  = 8'h0A  // Page fault pending
  } capi_response_t;

endpackage

// ==== common/wed_pkg.sv ====
package wed_pkg;

  // Controller states
  typedef enum logic [2:0] {
    WED_RESET,
    WED_IDLE,
    WED_REQ,
    WED_WAIT,
    WED_DONE
  } wed_state_t;

  //////////////////////////////////////////////////
  // Descriptor layout inside the cacheline
  //////////////////////////////////////////////////

  localparam int LINE_W = 2 * capi_pkg::HALF_W; // Both halves

  localparam int SRC_W     = 64;
  localparam int DST_W     = 64;
  localparam int SIZE_W    = 32;
  localparam int FLAGS_W   = 32;
  localparam int SRC_LSB   = 0;                     // Half 0
  localparam int DST_LSB   = 64;                    // Half 0
  localparam int SIZE_LSB  = capi_pkg::HALF_W;      // Half 1
  localparam int FLAGS_LSB = capi_pkg::HALF_W + 32; // Half 1

  typedef struct packed {
    logic [FLAGS_W-1:0] flags;
    logic [SIZE_W-1:0]  size;
    logic [DST_W-1:0]   dst;
    logic [SRC_W-1:0]   src;
  } wed_t;

  function automatic wed_t map_to_wed(input logic [LINE_W-1:0] line);
    wed_t wed;
    wed.src   = line[SRC_LSB +: SRC_W];
    wed.dst   = line[DST_LSB +: DST_W];
    wed.size  = line[SIZE_LSB +: SIZE_W];
    wed.flags = line[FLAGS_LSB +: FLAGS_W];
    return wed;
  endfunction

endpackage

// ==== dv/wed_fetch_tb.sv ====
module wed_fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int timeout_cycles = 64;
  localparam int iterations     = 200;
  localparam int wait_limit     = 400; // Edges allowed for any single wait

  logic                            clock = 1'b0;
  logic                            rstn;
  logic                            enabled;
  logic [capi_pkg::ADDR_W-1:0]     wed_address;
  logic                            wed_release;
  logic                            command_full = 1'b0;
  logic                            write_valid;
  logic [capi_pkg::TAG_W-1:0]      write_tag;
  logic [capi_pkg::BUF_ADDR_W-1:0] write_address;
  logic [capi_pkg::HALF_W-1:0]     write_data;
  logic                            response_valid;
  logic [capi_pkg::TAG_W-1:0]      response_tag;
  capi_pkg::capi_response_t        response_code;
  logic                            command_valid;
  capi_pkg::capi_command_t         command_opcode;
  logic [capi_pkg::TAG_W-1:0]      command_tag;
  logic [capi_pkg::ADDR_W-1:0]     command_address;
  logic [capi_pkg::SIZE_W-1:0]     command_size;
  logic                            wed_valid;
  logic [63:0]                     wed_src;
  logic [63:0]                     wed_dst;
  logic [31:0]                     wed_size;
  logic [31:0]                     wed_flags;

  logic [1023:0] host_mem [logic [63:0]]; // One line per host address
  logic [63:0]   cur_addr     = '0;
  logic          expect_cmd   = 1'b0;       // A command may appear now
  logic          quiet_full   = 1'b0;       // Hold command_full low
  logic          last_full    = 1'b0;
  logic          last_valid   = 1'b0;
  logic          last_release = 1'b0;

  wed_fetch_top #(.timeout_cycles(timeout_cycles)) dut (.*);

  always #10 clock = ~clock;

  //////////////////////////////////////////////////
  // Error reporting and random helpers
  //////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_value_mismatch(input string name, input logic [63:0] got,
                                       input logic [63:0] expected);
    stop_run($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  function automatic logic [1023:0] random_line();
    logic [1023:0] ln;
    for (int i = 0; i < 32; i++) ln[i*32 +: 32] = $urandom;
    return ln;
  endfunction

  function automatic logic [1023:0] line_at(input logic [63:0] addr);
    if (!host_mem.exists(addr)) host_mem[addr] = random_line(); // Filled on first use
    return host_mem[addr];
  endfunction

  function automatic logic [capi_pkg::TAG_W-1:0] foreign_tag();
    logic [capi_pkg::TAG_W-1:0] tag;
    tag = capi_pkg::TAG_W'($urandom);
    if (tag == capi_pkg::WED_TAG) tag = tag ^ 8'h01;
    return tag;
  endfunction

  function automatic capi_pkg::capi_response_t random_code();
    case ($urandom_range(0, 3))
      0:       return capi_pkg::DONE;
      1:       return capi_pkg::AERROR;
      2:       return capi_pkg::FAILED;
      default: return capi_pkg::PAGED;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Command and descriptor monitor
  //////////////////////////////////////////////////

  always @(posedge clock) begin
    if (command_valid) begin
      assert (expect_cmd) else stop_run("command issued with no fetch pending");
      assert (!last_full) else stop_run("command issued while command_full was high");
      assert (command_opcode == capi_pkg::READ_CL_NA)
        else report_value_mismatch("command_opcode", 64'(command_opcode), 64'h0A00);
      assert (command_tag == capi_pkg::WED_TAG)
        else report_value_mismatch("command_tag", 64'(command_tag), 64'(capi_pkg::WED_TAG));
      assert (command_size == 12'd128)
        else report_value_mismatch("command_size", 64'(command_size), 64'd128);
      assert (command_address == cur_addr)
        else report_value_mismatch("command_address", command_address, cur_addr);
    end
    if (last_valid && !wed_valid) begin
      assert (last_release) else stop_run("wed_valid dropped without wed_release");
    end
    last_full    <= command_full;
    last_valid   <= wed_valid;
    last_release <= wed_release;
  end

  // Random back-pressure
  always @(posedge clock) begin
    if (quiet_full || !rstn) command_full <= 1'b0;
    else                     command_full <= ($urandom_range(0, 3) == 0);
  end

  //////////////////////////////////////////////////
  // Host model
  //////////////////////////////////////////////////

  task automatic wait_command(output int edges);
    edges = 0;
    do begin
      @(posedge clock);
      edges++;
      if (edges > wait_limit) stop_run("timed out waiting for command_valid");
    end while (!command_valid);
  endtask

  // Foreign traffic that must not touch the descriptor
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      write_valid    <= ($urandom_range(0, 2) == 0);
      write_tag      <= foreign_tag();
      write_address  <= 6'($urandom_range(0, 63));
      write_data     <= {16{$urandom}};
      response_valid <= ($urandom_range(0, 3) == 0);
      response_tag   <= foreign_tag();
      response_code  <= random_code();
    end
  endtask

  task automatic deliver_line(input logic [1023:0] ln);
    int first;
    first = $urandom_range(0, 1); // Halves in random order
    idle_cycles($urandom_range(0, 12));
    for (int i = 0; i < 2; i++) begin
      @(posedge clock);
      write_valid    <= 1'b1;
      write_tag      <= capi_pkg::WED_TAG;
      write_address  <= 6'(i ^ first);
      write_data     <= ln[(i ^ first)*512 +: 512];
      response_valid <= 1'b0;
    end
    idle_cycles($urandom_range(0, 8));
  endtask

  task automatic send_response(input capi_pkg::capi_response_t code);
    @(posedge clock);
    write_valid    <= 1'b0;
    response_valid <= 1'b1;
    response_tag   <= capi_pkg::WED_TAG;
    response_code  <= code;
    @(posedge clock);
    response_valid <= 1'b0;
  endtask

  task automatic check_fields(input logic [1023:0] ln);
    assert (wed_src == ln[63:0]) else report_value_mismatch("wed_src", wed_src, ln[63:0]);
    assert (wed_dst == ln[127:64]) else report_value_mismatch("wed_dst", wed_dst, ln[127:64]);
    assert (wed_size == ln[543:512])
      else report_value_mismatch("wed_size", 64'(wed_size), 64'(ln[543:512]));
    assert (wed_flags == ln[575:544])
      else report_value_mismatch("wed_flags", 64'(wed_flags), 64'(ln[575:544]));
  endtask

  task automatic run_fetch();
    logic [63:0]   addr;
    logic [1023:0] ln;
    int            mode;
    int            edges;
    addr = {$urandom, $urandom} & ~64'h7F; // Line aligned
    ln   = line_at(addr);
    mode = $urandom_range(0, 4);           // 0 failure first, 1 timeout first
    @(posedge clock);
    wed_address <= addr;
    cur_addr    <= addr;
    enabled     <= 1'b1;
    expect_cmd  <= 1'b1;
    wait_command(edges);
    if (mode == 0) begin
      deliver_line(random_line()); // Thrown away by the retry
      send_response(capi_pkg::FAILED);
      wait_command(edges);
    end else if (mode == 1) begin
      quiet_full <= 1'b1;
      wait_command(edges);
      assert (edges == timeout_cycles)
        else report_value_mismatch("reissue delay", 64'(edges), 64'(timeout_cycles));
      quiet_full <= 1'b0;
    end
    expect_cmd <= 1'b0;
    deliver_line(ln);
    send_response(capi_pkg::DONE);
    @(posedge clock);
    assert (!wed_valid) else report_value_mismatch("wed_valid", 64'(wed_valid), 64'h0);
    @(posedge clock);
    assert (wed_valid) else report_value_mismatch("wed_valid", 64'(wed_valid), 64'h1);
    check_fields(ln);
    repeat ($urandom_range(0, 6)) begin // Consumer holds the descriptor
      @(posedge clock);
      assert (wed_valid) else report_value_mismatch("wed_valid", 64'(wed_valid), 64'h1);
      check_fields(ln);
    end
    wed_release <= 1'b1;
    enabled     <= 1'b0;
    @(posedge clock);
    wed_release <= 1'b0;
    @(posedge clock);
    assert (!wed_valid) else report_value_mismatch("wed_valid", 64'(wed_valid), 64'h0);
  endtask

  initial begin
    void'($urandom(77));
    rstn           = 1'b0;
    enabled        = 1'b0;
    wed_address    = '0;
    wed_release    = 1'b0;
    write_valid    = 1'b0;
    write_tag      = '0;
    write_address  = '0;
    write_data     = '0;
    response_valid = 1'b0;
    response_tag   = '0;
    response_code  = capi_pkg::DONE;
    repeat (16) @(posedge clock);
    rstn <= 1'b1;
    repeat (20) begin // Nothing moves while disabled
      @(posedge clock);
      assert (!command_valid)
        else report_value_mismatch("command_valid", 64'(command_valid), 64'h0);
      assert (!wed_valid) else report_value_mismatch("wed_valid", 64'(wed_valid), 64'h0);
    end
    for (int iter = 0; iter < iterations; iter++) run_fetch();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hdl/response_timer.sv ====
module response_timer #(
  parameter int timeout_cycles = 64 // Must be at least 2
) (
  input  logic clock,
  input  logic rstn,
  input  logic timer_start,
  input  logic timer_stop,
  output logic timeout
);

  localparam int count_w = $clog2(timeout_cycles + 1);

  logic               running;
  logic [count_w-1:0] count;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      running <= 1'b0;
      count   <= '0;
    end else if (timer_start) begin
      running <= 1'b1;
      count   <= count_w'(2);    // Reissue path adds two edges
    end else if (timer_stop || timeout) begin
      running <= 1'b0;           // One shot
    end else if (running) begin
      count   <= count + 1'b1;
    end
  end

  assign timeout = running && (count == count_w'(timeout_cycles));

endmodule

// ==== hdl/wed_fetch_top.sv ====
module wed_fetch_top #(
  parameter int timeout_cycles = 64 // Cycles from command to reissue
) (
  input  logic                                   clock,
  input  logic                                   rstn,
  input  logic                                   enabled,
  input  logic [capi_pkg::ADDR_W-1:0]            wed_address,
  input  logic                                   wed_release,
  input  logic                                   command_full,
  input  logic                                   write_valid,
  input  logic [capi_pkg::TAG_W-1:0]             write_tag,
  input  logic [capi_pkg::BUF_ADDR_W-1:0]        write_address,
  input  logic [capi_pkg::HALF_W-1:0]            write_data,
  input  logic                                   response_valid,
  input  logic [capi_pkg::TAG_W-1:0]             response_tag,
  input  capi_pkg::capi_response_t               response_code,
  output logic                                   command_valid,
  output capi_pkg::capi_command_t                command_opcode,
  output logic [capi_pkg::TAG_W-1:0]             command_tag,
  output logic [capi_pkg::ADDR_W-1:0]            command_address,
  output logic [capi_pkg::SIZE_W-1:0]            command_size,
  output logic                                   wed_valid,
  output logic [wed_pkg::SRC_W-1:0]              wed_src,
  output logic [wed_pkg::DST_W-1:0]              wed_dst,
  output logic [wed_pkg::SIZE_W-1:0]             wed_size,
  output logic [wed_pkg::FLAGS_W-1:0]            wed_flags
);

  logic                       timer_start;
  logic                       timer_stop;
  logic                       timeout;
  logic                       capture_enable;
  logic                       line_clear;
  logic [wed_pkg::LINE_W-1:0] line;

  wed_control u_wed_control (.*);

  response_timer #(
    .timeout_cycles(timeout_cycles)
  ) u_response_timer (
    .clock      (clock),
    .rstn       (rstn),
    .timer_start(timer_start),
    .timer_stop (timer_stop),
    .timeout    (timeout)
  );

  wed_line_assembler u_wed_line_assembler (
    .clock         (clock),
    .rstn          (rstn),
    .capture_enable(capture_enable),
    .line_clear    (line_clear),
    .write_valid   (write_valid),
    .write_tag     (write_tag),
    .write_address (write_address),
    .write_data    (write_data),
    .line          (line)
  );

endmodule

// ==== wed_control/wed_control.sv ====
module wed_control (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic                            enabled,
  input  logic [capi_pkg::ADDR_W-1:0]     wed_address,
  input  logic                            wed_release,
  input  logic                            command_full,
  input  logic                            response_valid,
  input  logic [capi_pkg::TAG_W-1:0]      response_tag,
  input  capi_pkg::capi_response_t        response_code,
  input  logic                            timeout,
  input  logic [wed_pkg::LINE_W-1:0]      line,
  output logic                            command_valid,
  output capi_pkg::capi_command_t         command_opcode,
  output logic [capi_pkg::TAG_W-1:0]      command_tag,
  output logic [capi_pkg::ADDR_W-1:0]     command_address,
  output logic [capi_pkg::SIZE_W-1:0]     command_size,
  output logic                            timer_start,
  output logic                            timer_stop,
  output logic                            capture_enable,
  output logic                            line_clear,
  output logic                            wed_valid,
  output logic [wed_pkg::SRC_W-1:0]       wed_src,
  output logic [wed_pkg::DST_W-1:0]       wed_dst,
  output logic [wed_pkg::SIZE_W-1:0]      wed_size,
  output logic [wed_pkg::FLAGS_W-1:0]     wed_flags
);

  wed_pkg::wed_state_t current_state, next_state;
  wed_pkg::wed_t       wed_fields;

  logic resp_hit, resp_done, start_fetch, issue, retry;

  assign resp_hit    = response_valid && (response_tag == capi_pkg::WED_TAG);
  assign resp_done   = resp_hit && (response_code == capi_pkg::DONE);
  assign start_fetch = (current_state == wed_pkg::WED_IDLE) && enabled &&
                       !wed_valid && !command_full;
  assign issue       = (current_state == wed_pkg::WED_REQ) && !command_full;
  // DONE wins over a timeout in the same cycle
  assign retry       = (current_state == wed_pkg::WED_WAIT) && !resp_done &&
                       (resp_hit || timeout);

  assign timer_start    = issue;
  assign timer_stop     = (current_state == wed_pkg::WED_WAIT) && resp_hit;
  assign capture_enable = (current_state == wed_pkg::WED_WAIT);
  assign line_clear     = start_fetch || retry; // Fresh line per attempt
  assign wed_fields     = wed_pkg::map_to_wed(line);

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) current_state <= wed_pkg::WED_RESET;
    else       current_state <= next_state;
  end

  always_comb begin
    next_state = wed_pkg::WED_IDLE;
    case (current_state)
      wed_pkg::WED_RESET: next_state = wed_pkg::WED_IDLE;
      wed_pkg::WED_IDLE:  next_state = start_fetch ? wed_pkg::WED_REQ : wed_pkg::WED_IDLE;
      wed_pkg::WED_REQ:   next_state = issue ? wed_pkg::WED_WAIT : wed_pkg::WED_REQ;
      wed_pkg::WED_WAIT: begin
        if (resp_done)  next_state = wed_pkg::WED_DONE;
        else if (retry) next_state = wed_pkg::WED_REQ;  // Failure or timeout
        else            next_state = wed_pkg::WED_WAIT;
      end
      wed_pkg::WED_DONE:  next_state = wed_pkg::WED_IDLE;
      default:            next_state = wed_pkg::WED_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Command and descriptor outputs
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      command_valid <= 1'b0;
      wed_valid     <= 1'b0;
    end else begin
      command_valid <= issue;                                   // One cycle pulse
      if (current_state == wed_pkg::WED_DONE) wed_valid <= 1'b1;
      else if (wed_release)                   wed_valid <= 1'b0; // Held for consumer
    end
  end

  always_ff @(posedge clock) begin
    if (current_state == wed_pkg::WED_RESET) begin
      command_opcode <= capi_pkg::INVALID; // Clean bus after reset
      command_tag    <= '0;
    end else if (issue) begin
      command_opcode  <= capi_pkg::READ_CL_NA;
      command_tag     <= capi_pkg::WED_TAG;
      command_address <= wed_address;
      command_size    <= capi_pkg::WED_READ_SIZE;
    end
    if (current_state == wed_pkg::WED_DONE) begin
      wed_src   <= wed_fields.src;
      wed_dst   <= wed_fields.dst;
      wed_size  <= wed_fields.size;
      wed_flags <= wed_fields.flags;
    end
  end

endmodule

// ==== wed_control/wed_line_assembler.sv ====
module wed_line_assembler (
  input  logic                              clock,
  input  logic                              rstn,
  input  logic                              capture_enable,
  input  logic                              line_clear,
  input  logic                              write_valid,
  input  logic [capi_pkg::TAG_W-1:0]        write_tag,
  input  logic [capi_pkg::BUF_ADDR_W-1:0]   write_address,
  input  logic [capi_pkg::HALF_W-1:0]       write_data,
  output logic [wed_pkg::LINE_W-1:0]        line
);

  logic                            write_valid_q;
  logic [capi_pkg::TAG_W-1:0]      write_tag_q;
  logic [capi_pkg::BUF_ADDR_W-1:0] write_address_q;
  logic [capi_pkg::HALF_W-1:0]     write_data_q;
  logic [capi_pkg::HALF_W-1:0]     half_0, half_1;
  logic                            hit;

  //////////////////////////////////////////////////
  // Latch the buffer write port
  //////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) write_valid_q <= 1'b0;
    else       write_valid_q <= write_valid;
  end

  always_ff @(posedge clock) begin
    write_tag_q     <= write_tag;
    write_address_q <= write_address;
    write_data_q    <= write_data;
  end

  // Only descriptor beats count
  assign hit = capture_enable && write_valid_q && (write_tag_q == capi_pkg::WED_TAG);

  always_ff @(posedge clock) begin
    if (line_clear) begin
      half_0 <= '0;
      half_1 <= '0;
    end else if (hit) begin
      if (write_address_q == 6'd0) half_0 <= write_data_q; // Bytes 0 to 63
      if (write_address_q == 6'd1) half_1 <= write_data_q; // Bytes 64 to 127
    end
  end

  assign line = {half_1, half_0};

endmodule

// ==== wed_fetch_top.f ====
common/capi_pkg.sv
common/wed_pkg.sv
hdl/response_timer.sv
wed_control/wed_line_assembler.sv
wed_control/wed_control.sv
hdl/wed_fetch_top.sv
dv/wed_fetch_tb.sv
